// ==== Makefile ====
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = vmem_unit_tb
FILELIST = vlog.f
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/vmem_unit_assertions.sv ====
/*
  Protocol checks on the vector memory unit, attached by bind.
  Checks are off while resetn is low.
  fail_count lets the testbench include assertion failures in its verdict.
*/
`timescale 1ns/1ps

module vmem_unit_assertions (
  input logic                       clk,
  input logic                       resetn,
  input logic                       stall,
  input logic                       dmem_en,
  input logic                       dmem_we,
  input vmem_cfg_pkg::addr_t        dmem_address,
  input vmem_cfg_pkg::byteen_t      dmem_byteen,
  input vmem_cfg_pkg::line_t        dmem_writedata,
  input logic                       dmem_wait,
  input vmem_cfg_pkg::lane_mask_t   voutput_we
);

  import vmem_cfg_pkg::*;
  import vmem_op_pkg::*;

  mem_req_t req;
  int       fail_count = 0;

  // The whole request is one value, so a single stability check covers it
  assign req.en        = dmem_en;
  assign req.we        = dmem_we;
  assign req.address   = dmem_address;
  assign req.byteen    = dmem_byteen;
  assign req.writedata = dmem_writedata;

  // A waited request must come back unchanged in the next cycle
  req_held: assert property (@(posedge clk) disable iff (!resetn)
    (req.en && dmem_wait) |=> $stable(req))
  else
  begin
    fail_count++;
    $error("Memory request changed while dmem_wait was high");
  end

  // Only one lane is written back per cycle
  we_onehot: assert property (@(posedge clk) disable iff (!resetn) $onehot0(voutput_we))
  else
  begin
    fail_count++;
    $error("voutput_we has more than one bit set");
  end

  // Requests only happen while an instruction holds the pipeline
  en_in_stall: assert property (@(posedge clk) disable iff (!resetn) !stall |-> !dmem_en)
  else
  begin
    fail_count++;
    $error("dmem_en high while stall is low");
  end

endmodule

// ==== dv/vmem_unit_tb.sv ====
/*
  Testbench of the vector memory unit with a 1 KiB byte memory model.
  Addresses wrap at 1 KiB, accesses must be naturally aligned.
  Load data returns one cycle after acceptance; dmem_wait is random when enabled.
*/
`timescale 1ns/1ps

module vmem_unit_tb;

  import vmem_cfg_pkg::*;
  import vmem_op_pkg::*;

  // Expected writeback of one load lane
  typedef struct packed {
    lane_idx_t lane;
    elem_t     value;
  } load_exp_t;

  localparam int num_instr      = 18;
  localparam int timeout_cycles = 200 * num_instr;

  logic       clk;
  logic       resetn;
  logic       enable;
  mem_op_t    op;
  addr_t      cbase;
  addr_t      cstride;
  lane_mask_t vmask;
  vec_t       vwritedata;
  logic       stall;
  vec_t       voutput;
  lane_mask_t voutput_we;
  logic       dmem_en;
  logic       dmem_we;
  addr_t      dmem_address;
  byteen_t    dmem_byteen;
  line_t      dmem_writedata;
  line_t      dmem_readdata;
  logic       dmem_wait;

  // mem is the model the DUT sees, shadow is what the rules predict
  logic [7:0] mem [0:1023];
  logic [7:0] shadow [0:1023];
  mem_req_t   exp_req_q[$];
  load_exp_t  exp_load_q[$];
  logic       wait_on;
  int         mismatch_count;
  int         fail_count;
  int         cycle_count;

  vmem_unit i_vmem_unit (
    .clk            (clk),
    .resetn         (resetn),
    .enable         (enable),
    .op             (op),
    .cbase          (cbase),
    .cstride        (cstride),
    .vmask          (vmask),
    .vwritedata     (vwritedata),
    .stall          (stall),
    .voutput        (voutput),
    .voutput_we     (voutput_we),
    .dmem_en        (dmem_en),
    .dmem_we        (dmem_we),
    .dmem_address   (dmem_address),
    .dmem_byteen    (dmem_byteen),
    .dmem_writedata (dmem_writedata),
    .dmem_readdata  (dmem_readdata),
    .dmem_wait      (dmem_wait)
  );

  bind vmem_unit vmem_unit_assertions i_vmem_unit_assertions (
    .clk            (clk),
    .resetn         (resetn),
    .stall          (stall),
    .dmem_en        (dmem_en),
    .dmem_we        (dmem_we),
    .dmem_address   (dmem_address),
    .dmem_byteen    (dmem_byteen),
    .dmem_writedata (dmem_writedata),
    .dmem_wait      (dmem_wait),
    .voutput_we     (voutput_we)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Every address bit shapes the initial byte
  function automatic logic [7:0] fill_byte(int i);
    return 8'(i * 13) ^ 8'(i >> 3);
  endfunction

  function automatic logic [9:0] mem_idx(addr_t a);
    return a[9:0];
  endfunction

  function automatic mem_op_t make_op(access_pattern_e p, elem_size_e s, logic sgn, logic st);
    mem_op_t o;
    o.pattern   = p;
    o.size      = s;
    o.is_signed = sgn;
    o.is_store  = st;
    return o;
  endfunction

  // Lane n sits at base plus n element strides, each stride scaled to bytes
  function automatic addr_t lane_addr(mem_op_t o, addr_t base, addr_t stride, int lane);
    addr_t step;
    step = (o.pattern == pat_unit) ? addr_t'(1) : stride;
    return base + addr_t'(lane) * step * addr_t'(1 << o.size);
  endfunction

  // Expected load element, little endian bytes from shadow then extension
  function automatic elem_t ref_load(mem_op_t o, addr_t base, addr_t stride, int lane);
    addr_t a;
    int    nbytes;
    elem_t v;
    a      = lane_addr(o, base, stride, lane);
    nbytes = 1 << o.size;
    v      = '0;
    for (int i = 0; i < nbytes; i++)
      v[i*8 +: 8] = shadow[mem_idx(a + addr_t'(i))];
    if (o.is_signed && nbytes < 4 && v[nbytes*8-1])
      v = v | (~elem_t'(0) << (nbytes * 8));
    return v;
  endfunction

  function automatic line_t read_line(addr_t a);
    line_t l;
    for (int b = 0; b < line_bytes; b++)
      l[b*8 +: 8] = mem[{a[9:4], 4'(b)}];
    return l;
  endfunction

  task automatic report_failure(string what);
    fail_count++;
    $display("Error: %s", what);
  endtask

  task automatic check_elem(string name, elem_t got, elem_t want);
    if (got !== want)
    begin
      mismatch_count++;
      $display("Mismatch %s: got %h, expected %h", name, got, want);
    end
  endtask

  task automatic check_addr(string name, addr_t got, addr_t want);
    if (got !== want)
    begin
      mismatch_count++;
      $display("Mismatch %s: got %h, expected %h", name, got, want);
    end
  endtask

  task automatic check_mask(string name, lane_mask_t got, lane_mask_t want);
    if (got !== want)
    begin
      mismatch_count++;
      $display("Mismatch %s: got %h, expected %h", name, got, want);
    end
  endtask

  // Bytes outside the enables carry no meaning and are blanked before comparing
  task automatic check_write(string name, line_t got, byteen_t got_be, line_t want,
                             byteen_t want_be);
    line_t got_m;
    line_t want_m;
    got_m  = '0;
    want_m = '0;
    for (int b = 0; b < line_bytes; b++)
    begin
      if (want_be[b])
      begin
        got_m[b*8 +: 8]  = got[b*8 +: 8];
        want_m[b*8 +: 8] = want[b*8 +: 8];
      end
    end
    if (got_be !== want_be)
    begin
      mismatch_count++;
      $display("Mismatch %s byteen: got %h, expected %h", name, got_be, want_be);
    end
    if (got_m !== want_m)
    begin
      mismatch_count++;
      $display("Mismatch %s: got %h, expected %h", name, got_m, want_m);
    end
  endtask

  task automatic compare_memory();
    for (int w = 0; w < 256; w++)
      check_elem($sformatf("memory word %h", w * 4),
                 {mem[w*4+3], mem[w*4+2], mem[w*4+1], mem[w*4]},
                 {shadow[w*4+3], shadow[w*4+2], shadow[w*4+1], shadow[w*4]});
  endtask

  // Queues the expected requests and writebacks, then runs one instruction
  task automatic run_op(mem_op_t o, addr_t base, addr_t stride, lane_mask_t mask);
    vec_t      wdata;
    mem_req_t  req;
    load_exp_t ld;
    addr_t     a;
    elem_t     e;
    int        nbytes;
    int        off;
    nbytes = 1 << o.size;
    for (int l = 0; l < num_lanes; l++)
      wdata[l*elem_w +: elem_w] = $urandom;
    for (int l = 0; l < num_lanes; l++)
    begin
      if (mask[l])
      begin
        a             = lane_addr(o, base, stride, l);
        off           = int'(a[3:0]);
        req           = '0;
        req.en        = 1'b1;
        req.we        = o.is_store;
        req.address   = a;
        if (o.is_store)
        begin
          e = wdata[l*elem_w +: elem_w];
          for (int i = 0; i < nbytes; i++)
          begin
            req.byteen[off + i]               = 1'b1;
            req.writedata[(off + i)*8 +: 8]   = e[i*8 +: 8];
            shadow[mem_idx(a + addr_t'(i))]   = e[i*8 +: 8];
          end
        end
        else
        begin
          ld.lane  = lane_idx_t'(l);
          ld.value = ref_load(o, base, stride, l);
          exp_load_q.push_back(ld);
        end
        exp_req_q.push_back(req);
      end
    end
    @(posedge clk);
    #1;
    enable     = 1'b1;
    op         = o;
    cbase      = base;
    cstride    = stride;
    vmask      = mask;
    vwritedata = wdata;
    @(posedge clk);
    #1;
    enable = 1'b0;
    @(negedge clk);
    if (stall !== 1'b1)
      report_failure("stall did not rise after enable");
    while (stall === 1'b1)
      @(negedge clk);
    if (exp_req_q.size() != 0)
      report_failure("stall fell with memory requests still pending");
    // The last load lane writes back in the cycle where stall is already low
    @(negedge clk);
    if (exp_load_q.size() != 0)
      report_failure("load lanes missing from voutput_we");
    if (o.is_store)
      compare_memory();
  endtask

  // Memory model, samples the port mid-cycle and answers just after the edge
  initial
  begin : memory_model
    mem_req_t acc;
    logic     hit;
    dmem_wait     = 1'b0;
    dmem_readdata = '0;
    for (int i = 0; i < 1024; i++)
      mem[i] = fill_byte(i);
    forever
    begin
      @(negedge clk);
      hit           = resetn && dmem_en === 1'b1 && dmem_wait === 1'b0;
      acc.en        = dmem_en;
      acc.we        = dmem_we;
      acc.address   = dmem_address;
      acc.byteen    = dmem_byteen;
      acc.writedata = dmem_writedata;
      @(posedge clk);
      #1;
      if (hit && acc.we)
      begin
        for (int b = 0; b < line_bytes; b++)
          if (acc.byteen[b])
            mem[{acc.address[9:4], 4'(b)}] = acc.writedata[b*8 +: 8];
      end
      else if (hit)
        dmem_readdata = read_line(acc.address);
      dmem_wait = wait_on && ($urandom % 3 == 0);
    end
  end

  // Compares each accepted request and each writeback against the queues
  always @(negedge clk)
  begin : compare_outputs
    mem_req_t  req;
    load_exp_t ld;
    if (resetn)
    begin
      if (dmem_en === 1'b1 && dmem_wait === 1'b0)
      begin
        if (exp_req_q.size() == 0)
          report_failure("memory request with no lane pending");
        else
        begin
          req = exp_req_q.pop_front();
          check_addr("dmem_address", dmem_address, req.address);
          if (dmem_we !== req.we)
            report_failure("dmem_we does not match the operation");
          else if (req.we)
            check_write("dmem_writedata", dmem_writedata, dmem_byteen, req.writedata,
                        req.byteen);
        end
      end
      if (voutput_we !== lane_mask_t'(0))
      begin
        if (exp_load_q.size() == 0)
          report_failure("voutput_we pulsed with no load lane pending");
        else
        begin
          ld = exp_load_q.pop_front();
          check_mask("voutput_we", voutput_we, lane_mask_t'(1) << ld.lane);
          for (int l = 0; l < num_lanes; l++)
            check_elem($sformatf("voutput[%0d]", l), voutput[l*elem_w +: elem_w],
                       (l == int'(ld.lane)) ? ld.value : elem_t'(0));
        end
      end
    end
  end

  initial
  begin : watchdog
    cycle_count = 0;
    while (cycle_count < timeout_cycles)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
    $display("TESTS FAILED");
    $finish;
  end

  initial
  begin : stimulus
    int total;
    void'($urandom(32'he6be));
    mismatch_count = 0;
    fail_count     = 0;
    wait_on        = 1'b0;
    resetn         = 1'b0;
    enable         = 1'b0;
    op             = '0;
    cbase          = '0;
    cstride        = '0;
    vmask          = '0;
    vwritedata     = '0;
    for (int i = 0; i < 1024; i++)
      shadow[i] = fill_byte(i);
    repeat (16) @(posedge clk);
    #1;
    resetn = 1'b1;
    @(negedge clk);
    if (stall !== 1'b0)
      report_failure("stall not low after reset");
    if (dmem_en !== 1'b0)
      report_failure("dmem_en not low after reset");
    check_mask("voutput_we", voutput_we, lane_mask_t'(0));

    // Loads of every size, strides chosen so lanes cross lines
    run_op(make_op(pat_unit, size_word, 1'b0, 1'b0), 32'h040, 32'h0, 8'hff);
    run_op(make_op(pat_stride, size_byte, 1'b1, 1'b0), 32'h103, 32'h5, 8'hff);
    run_op(make_op(pat_stride, size_byte, 1'b0, 1'b0), 32'h1f1, 32'h7, 8'hff);
    run_op(make_op(pat_stride, size_half, 1'b1, 1'b0), 32'h202, 32'h3, 8'hff);
    run_op(make_op(pat_stride, size_half, 1'b0, 1'b0), 32'h0a6, 32'h9, 8'hff);

    // Stores of every size, then loads from the same places
    run_op(make_op(pat_unit, size_word, 1'b0, 1'b1), 32'h300, 32'h0, 8'hff);
    run_op(make_op(pat_stride, size_byte, 1'b0, 1'b1), 32'h381, 32'h3, 8'hff);
    run_op(make_op(pat_stride, size_half, 1'b0, 1'b1), 32'h3a2, 32'h5, 8'hff);
    run_op(make_op(pat_unit, size_word, 1'b0, 1'b0), 32'h300, 32'h0, 8'hff);
    run_op(make_op(pat_stride, size_byte, 1'b0, 1'b0), 32'h381, 32'h3, 8'hff);
    run_op(make_op(pat_stride, size_half, 1'b1, 1'b0), 32'h3a2, 32'h5, 8'hff);

    // Masked lanes leave memory alone and produce no writeback
    run_op(make_op(pat_stride, size_word, 1'b0, 1'b1), 32'h2c0, 32'h2, 8'ha5);
    run_op(make_op(pat_stride, size_word, 1'b0, 1'b0), 32'h2c0, 32'h2, 8'h5a);

    // Same kinds of access with the memory stretching requests
    wait_on = 1'b1;
    run_op(make_op(pat_unit, size_word, 1'b0, 1'b0), 32'h040, 32'h0, 8'hff);
    run_op(make_op(pat_stride, size_byte, 1'b1, 1'b0), 32'h103, 32'h5, 8'hff);
    run_op(make_op(pat_stride, size_half, 1'b0, 1'b1), 32'h3a2, 32'h5, 8'h3c);
    run_op(make_op(pat_stride, size_half, 1'b1, 1'b0), 32'h3a2, 32'h5, 8'hff);
    run_op(make_op(pat_unit, size_word, 1'b0, 1'b1), 32'h300, 32'h0, 8'hff);

    total = mismatch_count + fail_count + i_vmem_unit.i_vmem_unit_assertions.fail_count;
    $display("Error counts: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatch_count, fail_count, i_vmem_unit.i_vmem_unit_assertions.fail_count);
    if (total == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== source/vmem_addr_gen.sv ====
/*
  Running element address generator.
  The stride counts elements and is scaled by the element size.
  Address arithmetic wraps at 32 bits with no range check.
*/
`timescale 1ns/1ps

module vmem_addr_gen (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 start,
  input  logic                 advance,
  input  vmem_cfg_pkg::addr_t    base,
  input  vmem_cfg_pkg::addr_t    stride,
  input  vmem_op_pkg::mem_op_t   op,
  output vmem_cfg_pkg::addr_t    addr
);

  import vmem_cfg_pkg::*;
  import vmem_op_pkg::*;

  addr_t elem_stride;
  addr_t scaled_stride;
  addr_t stride_r;

  // Unit pattern steps one element at a time
  assign elem_stride   = (op.pattern == pat_unit) ? addr_t'(1) : stride;
  assign scaled_stride = elem_stride << op.size;

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      addr     <= '0;
      stride_r <= '0;
    end
    else if (start)
    begin
      addr     <= base;
      stride_r <= scaled_stride;
    end
    else if (advance)
      addr <= addr + stride_r;
  end

endmodule

// ==== source/vmem_cfg_pkg.sv ====
/*
  Configuration widths of the vector memory unit.
  The line must hold a whole number of elements, and the element is one word.
  Widths are fixed here; changing them needs matching changes in the aligners.
*/
package vmem_cfg_pkg;

  // Vector shape
  localparam int num_lanes  = 8;
  localparam int lane_idx_w = 3;
  localparam int elem_w     = 32;

  // Memory side
  localparam int addr_w     = 32;
  localparam int line_w     = 128;
  localparam int line_bytes = 16;

  // Bits of the address that pick a word within a line
  localparam int word_sel_w = 2;

  typedef logic [lane_idx_w-1:0]       lane_idx_t;
  typedef logic [elem_w-1:0]           elem_t;
  typedef logic [addr_w-1:0]           addr_t;
  typedef logic [line_w-1:0]           line_t;
  typedef logic [line_bytes-1:0]       byteen_t;
  typedef logic [num_lanes-1:0]        lane_mask_t;

  // All lanes side by side, lane 0 in the low bits
  typedef logic [num_lanes*elem_w-1:0] vec_t;

endpackage

// ==== source/vmem_issue_fsm.sv ====
/*
  Lane sequencer of the vector memory unit, one lane per memory access.
  A load lane expects its line exactly one cycle after acceptance.
  Stall is low in idle and in the one-cycle finish state.
*/
`timescale 1ns/1ps

module vmem_issue_fsm (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   enable,
  input  vmem_cfg_pkg::lane_mask_t mask,
  input  logic                   is_store,
  input  vmem_cfg_pkg::lane_idx_t  cur_lane,
  input  logic                   last_lane,
  input  logic                   dmem_wait,
  output logic                   start,
  output logic                   advance,
  output logic                   req_en,
  output logic                   load_capture,
  output logic                   stall
);

  import vmem_cfg_pkg::*;

  typedef enum logic [1:0] {
    idle,
    issue,
    wait_data,
    finish
  } state_e;

  state_e     state;
  state_e     state_next;
  lane_mask_t mask_r;
  logic       lane_active;
  logic       accepted;

  // A new instruction is only taken while the pipeline is not held
  assign start       = enable && !stall;
  assign stall       = (state == issue) || (state == wait_data);
  assign lane_active = mask_r[cur_lane];

  // The request stays up until memory drops its wait
  assign req_en   = (state == issue) && lane_active;
  assign accepted = req_en && !dmem_wait;

  // Returned line is on the bus in the wait_data cycle
  assign load_capture = (state == wait_data);

  // Masked lanes pass in one cycle, stores finish on acceptance
  assign advance = ((state == issue) && (!lane_active || (accepted && is_store))) ||
                   (state == wait_data);

  // The mask is sampled together with the rest of the instruction
  always_ff @(posedge clk)
  begin
    if (start)
      mask_r <= mask;
  end

  always_comb
  begin
    state_next = state;
    case (state)
      idle, finish:
        state_next = start ? issue : idle;
      issue:
        if (advance)
          state_next = last_lane ? finish : issue;
        else if (accepted)
          state_next = wait_data;
      wait_data:
        state_next = last_lane ? finish : issue;
      default:
        state_next = idle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!resetn)
      state <= idle;
    else
      state <= state_next;
  end

endmodule

// ==== source/vmem_lane_counter.sv ====
/*
  Lane index counter, steps lanes 0 to 7 in order.
  Wraps silently past the last lane; the sequencer stops before that.
*/
`timescale 1ns/1ps

module vmem_lane_counter (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  start,
  input  logic                  advance,
  output vmem_cfg_pkg::lane_idx_t cur_lane,
  output logic                  last_lane
);

  import vmem_cfg_pkg::*;

  // Highest lane index, the one whose advance ends the instruction
  localparam lane_idx_t last_idx = lane_idx_t'(num_lanes - 1);

  always_ff @(posedge clk)
  begin
    if (!resetn)
      cur_lane <= '0;
    else if (start)
      cur_lane <= '0;
    else if (advance)
      cur_lane <= cur_lane + lane_idx_t'(1);
  end

  assign last_lane = (cur_lane == last_idx);

endmodule

// ==== source/vmem_load_align.sv ====
/*
  Load aligner with one output register.
  The result appears one cycle after capture and lasts one cycle.
  Accesses are assumed naturally aligned within a word.
*/
`timescale 1ns/1ps

module vmem_load_align (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    capture,
  input  vmem_cfg_pkg::line_t       line,
  input  vmem_cfg_pkg::addr_t       addr,
  input  vmem_op_pkg::mem_op_t      op,
  input  vmem_cfg_pkg::lane_idx_t   lane,
  output vmem_cfg_pkg::vec_t        result,
  output vmem_cfg_pkg::lane_mask_t  result_we
);

  import vmem_cfg_pkg::*;
  import vmem_op_pkg::*;

  elem_t      word;
  logic [7:0] byte_val;
  logic [15:0] half_val;
  elem_t      value;
  vec_t       placed;

  // Word first, then the byte or half inside it
  assign word     = line[addr[2 +: word_sel_w] * elem_w +: elem_w];
  assign byte_val = word[addr[1:0] * 8 +: 8];
  assign half_val = word[addr[1] * 16 +: 16];

  always_comb
  begin
    case (op.size)
      size_byte:
        value = {{24{op.is_signed & byte_val[7]}}, byte_val};
      size_half:
        value = {{16{op.is_signed & half_val[15]}}, half_val};
      default:
        value = word;
    endcase
  end

  // Other lanes stay zero so the register file sees only this lane
  assign placed = vec_t'(value) << (lane * elem_w);

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      result    <= '0;
      result_we <= '0;
    end
    else if (capture)
    begin
      result    <= placed;
      result_we <= lane_mask_t'(1) << lane;
    end
    else
    begin
      result    <= '0;
      result_we <= '0;
    end
  end

endmodule

// ==== source/vmem_op_pkg.sv ====
/*
  Operation encoding of the vector memory unit.
  Indexed access is not encoded; only unit and strided patterns exist.
  The size code doubles as the stride shift amount.
*/
package vmem_op_pkg;

  import vmem_cfg_pkg::*;

  // Unit stride walks consecutive elements of the given size
  typedef enum logic {
    pat_unit   = 1'b0,
    pat_stride = 1'b1
  } access_pattern_e;

  // Code value equals log2 of the element size in bytes
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } elem_size_e;

  // One vector memory instruction, 5 bits
  typedef struct packed {
    access_pattern_e pattern;
    elem_size_e      size;
    logic            is_signed;
    logic            is_store;
  } mem_op_t;

  // One request on the memory port, 178 bits
  typedef struct packed {
    logic    en;
    logic    we;
    addr_t   address;
    byteen_t byteen;
    line_t   writedata;
  } mem_req_t;

endpackage

// ==== source/vmem_store_align.sv ====
/*
  Store aligner, purely combinational.
  Accesses are assumed naturally aligned; a half or word that
  crosses its word boundary is not split.
*/
`timescale 1ns/1ps

module vmem_store_align (
  input  vmem_cfg_pkg::elem_t      data,
  input  vmem_cfg_pkg::addr_t      addr,
  input  vmem_op_pkg::elem_size_e  size,
  output vmem_cfg_pkg::line_t      writedata,
  output vmem_cfg_pkg::byteen_t    byteen
);

  import vmem_cfg_pkg::*;
  import vmem_op_pkg::*;

  elem_t                 word_data;
  logic [3:0]            word_be;
  logic [word_sel_w-1:0] word_sel;

  // Word slot within the line, above the byte offset
  assign word_sel = addr[2 +: word_sel_w];

  // Copy the small value into every position so any offset finds it
  always_comb
  begin
    case (size)
      size_byte:
      begin
        word_data = {4{data[7:0]}};
        word_be   = 4'b0001 << addr[1:0];
      end
      size_half:
      begin
        word_data = {2{data[15:0]}};
        word_be   = 4'b0011 << {addr[1], 1'b0};
      end
      default:
      begin
        word_data = data;
        word_be   = 4'b1111;
      end
    endcase
  end

  // Only the enabled bytes matter, the rest of the line is don't care
  assign writedata = line_t'(word_data) << (word_sel * elem_w);
  assign byteen    = byteen_t'(word_be) << (word_sel * 4);

endmodule

// ==== source/vmem_unit.sv ====
/*
  Vector memory unit, 8 lanes of 32 bits over a 128-bit memory line.
  Serves one lane per access; expect roughly 1 to 2 cycles per lane plus waits.
  Memory must return load data exactly one cycle after acceptance.
*/
`timescale 1ns/1ps

module vmem_unit (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     enable,
  input  vmem_op_pkg::mem_op_t       op,
  input  vmem_cfg_pkg::addr_t        cbase,
  input  vmem_cfg_pkg::addr_t        cstride,
  input  vmem_cfg_pkg::lane_mask_t   vmask,
  input  vmem_cfg_pkg::vec_t         vwritedata,
  output logic                     stall,
  output vmem_cfg_pkg::vec_t         voutput,
  output vmem_cfg_pkg::lane_mask_t   voutput_we,
  output logic                     dmem_en,
  output logic                     dmem_we,
  output vmem_cfg_pkg::addr_t        dmem_address,
  output vmem_cfg_pkg::byteen_t      dmem_byteen,
  output vmem_cfg_pkg::line_t        dmem_writedata,
  input  vmem_cfg_pkg::line_t        dmem_readdata,
  input  logic                     dmem_wait
);

  import vmem_cfg_pkg::*;
  import vmem_op_pkg::*;

  mem_op_t   op_r;
  vec_t      wdata_r;
  logic      start;
  logic      advance;
  logic      req_en;
  logic      load_capture;
  lane_idx_t cur_lane;
  logic      last_lane;
  addr_t     addr;
  elem_t     store_elem;
  line_t     store_line;
  byteen_t   store_byteen;
  mem_req_t  req;

  // Instruction fields are held for the whole run
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      op_r    <= op;
      wdata_r <= vwritedata;
    end
  end

  assign store_elem = wdata_r[cur_lane * elem_w +: elem_w];

  vmem_issue_fsm i_vmem_issue_fsm (
    .clk          (clk),
    .resetn       (resetn),
    .enable       (enable),
    .mask         (vmask),
    .is_store     (op_r.is_store),
    .cur_lane     (cur_lane),
    .last_lane    (last_lane),
    .dmem_wait    (dmem_wait),
    .start        (start),
    .advance      (advance),
    .req_en       (req_en),
    .load_capture (load_capture),
    .stall        (stall)
  );

  vmem_lane_counter i_vmem_lane_counter (
    .clk       (clk),
    .resetn    (resetn),
    .start     (start),
    .advance   (advance),
    .cur_lane  (cur_lane),
    .last_lane (last_lane)
  );

  // Sees the live op because it loads in the start cycle
  vmem_addr_gen i_vmem_addr_gen (
    .clk     (clk),
    .resetn  (resetn),
    .start   (start),
    .advance (advance),
    .base    (cbase),
    .stride  (cstride),
    .op      (op),
    .addr    (addr)
  );

  vmem_store_align i_vmem_store_align (
    .data      (store_elem),
    .addr      (addr),
    .size      (op_r.size),
    .writedata (store_line),
    .byteen    (store_byteen)
  );

  // Address and lane still belong to the loading lane in the data cycle
  vmem_load_align i_vmem_load_align (
    .clk       (clk),
    .resetn    (resetn),
    .capture   (load_capture),
    .line      (dmem_readdata),
    .addr      (addr),
    .op        (op_r),
    .lane      (cur_lane),
    .result    (voutput),
    .result_we (voutput_we)
  );

  // Every field comes from registers, so it holds while memory waits
  assign req.en        = req_en;
  assign req.we        = req_en && op_r.is_store;
  assign req.address   = addr;
  assign req.byteen    = store_byteen;
  assign req.writedata = store_line;

  assign dmem_en        = req.en;
  assign dmem_we        = req.we;
  assign dmem_address   = req.address;
  assign dmem_byteen    = req.byteen;
  assign dmem_writedata = req.writedata;

endmodule

// ==== vlog.f ====
source/vmem_cfg_pkg.sv
source/vmem_op_pkg.sv
source/vmem_issue_fsm.sv
source/vmem_lane_counter.sv
source/vmem_addr_gen.sv
source/vmem_store_align.sv
source/vmem_load_align.sv
source/vmem_unit.sv
dv/vmem_unit_assertions.sv
dv/vmem_unit_tb.sv
